/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_tft_ctrl
FILELIST ?= tft_ctrl.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= All tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$($(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* design/frame_fetch.sv */
`timescale 1ns/1ps

module frame_fetch import tft_pkg::*; (
	input logic clkSYS,
	input logic n_reset,
	tft_timing_if.dst tim,
	input logic mem_valid,
	input logic req_ready,
	input logic pop,
	output logic [ADDR_W-1:0] req_addr,
	output logic request,
	output logic flush,
	output logic wr_en,
	output logic disp
);

	// FIFO words plus words still owed by memory
	logic [LEVEL_W-1:0] credit;
	// Words accepted but not yet returned
	logic [LEVEL_W-1:0] in_flight;
	logic flush_pending;
	logic accept;

	// Fetch starts with the first frame, then asks for a burst while one fits
	assign request = disp && !flush_pending && (credit + BURST_LEN <= FIFO_DEPTH);
	assign accept = request && req_ready;

	// Empty the FIFO once all outstanding data has landed
	assign flush = flush_pending && in_flight == '0;

	// Return data goes straight into the FIFO
	assign wr_en = mem_valid;

	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset)
			req_addr <= FRAME_BASE;
		else if (flush)
			req_addr <= FRAME_BASE;
		else if (accept)
			req_addr <= req_addr + ADDR_W'(BURST_LEN);
	end

	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset)
			credit <= '0;
		else if (flush)
			credit <= '0;
		else
			credit <= credit + (accept ? LEVEL_W'(BURST_LEN) : '0) - LEVEL_W'(pop);
	end

	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset)
			in_flight <= '0;
		else
			in_flight <= in_flight + (accept ? LEVEL_W'(BURST_LEN) : '0) - LEVEL_W'(mem_valid);
	end

	// New frame restarts at the base, display turns on with the first one
	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset) begin
			flush_pending <= 1'b0;
			disp <= 1'b0;
		end else begin
			if (tim.frame_start)
				flush_pending <= 1'b1;
			else if (flush)
				flush_pending <= 1'b0;
			if (flush)
				disp <= 1'b1;
		end
	end

	a_credit_bound: assert property (
		@(posedge clkSYS) disable iff (!n_reset)
		credit <= LEVEL_W'(FIFO_DEPTH)
	) else $error("frame_fetch: credit above FIFO depth");

	// Memory returns only what was asked for
	a_no_extra_data: assert property (
		@(posedge clkSYS) disable iff (!n_reset)
		mem_valid |-> in_flight != '0
	) else $error("frame_fetch: data returned with nothing in flight");

endmodule

/* design/pixel_fifo.sv */
`timescale 1ns/1ps

module pixel_fifo import tft_pkg::*; (
	input logic clkSYS,
	input logic n_reset,
	input logic flush,
	input logic wr_en,
	input rgb565_t wr_data,
	input logic pop,
	output rgb565_t head,
	output logic not_empty,
	output logic [LEVEL_W-1:0] level
);

	rgb565_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	// Storage
	always_ff @(posedge clkSYS) begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
	end

	// Pointers wrap at the depth, level tracks occupancy
	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			level <= level + LEVEL_W'(wr_en) - LEVEL_W'(pop);
		end
	end

	// Show-ahead read
	assign head = mem[rd_ptr];
	assign not_empty = level != '0;

	// Memory returns are unthrottled, so the fetch credit must keep room
	a_no_overflow: assert property (
		@(posedge clkSYS) disable iff (!n_reset)
		wr_en && !flush |-> level != LEVEL_W'(FIFO_DEPTH)
	) else $error("pixel_fifo: write while full");

	// Output stage checks not_empty before popping
	a_no_underflow: assert property (
		@(posedge clkSYS) disable iff (!n_reset)
		pop |-> not_empty
	) else $error("pixel_fifo: pop while empty");

endmodule

/* design/pixel_out.sv */
`timescale 1ns/1ps

module pixel_out import tft_pkg::*; (
	input logic clkSYS,
	input logic n_reset,
	tft_timing_if.dst tim,
	input rgb565_t head,
	input logic not_empty,
	output logic pop,
	output logic de,
	output logic hsync,
	output logic vsync,
	output logic [RGB_W-1:0] rgb,
	output logic underrun
);

	logic starved;

	// Take one word on every active cycle that has one
	assign pop = tim.active && not_empty;
	assign starved = tim.active && !not_empty;

	// Panel signals share one register stage so they stay aligned
	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset) begin
			de <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			rgb <= '0;
		end else begin
			de <= tim.active;
			hsync <= tim.hsync_n;
			vsync <= tim.vsync_n;
			// Zero fill of the low bits, black when nothing was popped
			if (pop)
				rgb <= {head.red, 3'b000, head.green, 2'b00, head.blue, 3'b000};
			else
				rgb <= '0;
		end
	end

	// Sticky until reset
	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset)
			underrun <= 1'b0;
		else if (starved)
			underrun <= 1'b1;
	end

endmodule

/* design/tft_ctrl.sv */
`timescale 1ns/1ps

module tft_ctrl import tft_pkg::*; (
	input logic clkSYS,
	input logic n_reset,

	// Memory read port
	input logic [DATA_W-1:0] mem_data,
	input logic mem_valid,
	input logic req_ready,
	output logic [ADDR_W-1:0] req_addr,
	output logic request,

	// Panel
	output logic disp,
	output logic de,
	output logic hsync,
	output logic vsync,
	output logic [RGB_W-1:0] rgb,

	// Status
	output logic underrun,
	output logic [LEVEL_W-1:0] level
);

	tft_timing_if tim_if ();

	logic flush;
	logic wr_en;
	logic pop;
	logic not_empty;
	rgb565_t head;

	tft_timing timing_i (
		.clkSYS (clkSYS),
		.n_reset (n_reset),
		.tim (tim_if.src)
	);

	frame_fetch fetch_i (
		.clkSYS (clkSYS),
		.n_reset (n_reset),
		.tim (tim_if.dst),
		.mem_valid (mem_valid),
		.req_ready (req_ready),
		.pop (pop),
		.req_addr (req_addr),
		.request (request),
		.flush (flush),
		.wr_en (wr_en),
		.disp (disp)
	);

	// Memory words are RGB565 as stored
	pixel_fifo fifo_i (
		.clkSYS (clkSYS),
		.n_reset (n_reset),
		.flush (flush),
		.wr_en (wr_en),
		.wr_data (rgb565_t'(mem_data)),
		.pop (pop),
		.head (head),
		.not_empty (not_empty),
		.level (level)
	);

	pixel_out out_i (
		.clkSYS (clkSYS),
		.n_reset (n_reset),
		.tim (tim_if.dst),
		.head (head),
		.not_empty (not_empty),
		.pop (pop),
		.de (de),
		.hsync (hsync),
		.vsync (vsync),
		.rgb (rgb),
		.underrun (underrun)
	);

endmodule

/* design/tft_pkg.sv */
package tft_pkg;

	// Memory bus widths
	localparam int ADDR_W = 24;
	localparam int DATA_W = 16;

	// Panel pixel width after expansion
	localparam int RGB_W = 24;

	// Burst fetch
	localparam int BURST_LEN = 4;
	localparam logic [ADDR_W-1:0] FRAME_BASE = 24'h100000;

	// Pixel FIFO, level counts 0 to FIFO_DEPTH
	localparam int FIFO_DEPTH = 32;
	localparam int LEVEL_W = 6;
	localparam int PTR_W = LEVEL_W - 1;

	function automatic int max4(int a, int b, int c, int d);
		int m;
		m = a;
		if (b > m)
			m = b;
		if (c > m)
			m = c;
		if (d > m)
			m = d;
		return m;
	endfunction

	// Horizontal phases in cycles, 28 per line
	localparam int H_SYNC = 4;
	localparam int H_BACK = 4;
	localparam int H_ACTIVE = 16;
	localparam int H_FRONT = 4;

	// Vertical phases in lines, 10 per frame
	localparam int V_SYNC = 2;
	localparam int V_BACK = 2;
	localparam int V_ACTIVE = 4;
	localparam int V_FRONT = 2;

	// Down-counters hold length - 1
	localparam int H_CNT_W = $clog2(max4(H_SYNC, H_BACK, H_ACTIVE, H_FRONT));
	localparam int V_CNT_W = $clog2(max4(V_SYNC, V_BACK, V_ACTIVE, V_FRONT));

	typedef enum logic [1:0] {
		PH_SYNC,
		PH_BACK,
		PH_ACTIVE,
		PH_FRONT
	} phase_t;

	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565_t;

endpackage

/* design/tft_timing.sv */
`timescale 1ns/1ps

module tft_timing import tft_pkg::*; (
	input logic clkSYS,
	input logic n_reset,
	tft_timing_if.src tim
);

	logic [H_CNT_W-1:0] h_cnt;
	logic [V_CNT_W-1:0] v_cnt;
	phase_t h_phase;
	phase_t v_phase;
	logic h_end;
	logic v_end;
	logic line_end;
	logic back_first;

	function automatic phase_t next_phase(phase_t ph);
		return phase_t'(ph + 2'd1);
	endfunction

	// Reload values are phase length minus one
	function automatic logic [H_CNT_W-1:0] h_reload(phase_t ph);
		case (ph)
			PH_SYNC: return H_CNT_W'(H_SYNC - 1);
			PH_BACK: return H_CNT_W'(H_BACK - 1);
			PH_ACTIVE: return H_CNT_W'(H_ACTIVE - 1);
			default: return H_CNT_W'(H_FRONT - 1);
		endcase
	endfunction

	function automatic logic [V_CNT_W-1:0] v_reload(phase_t ph);
		case (ph)
			PH_SYNC: return V_CNT_W'(V_SYNC - 1);
			PH_BACK: return V_CNT_W'(V_BACK - 1);
			PH_ACTIVE: return V_CNT_W'(V_ACTIVE - 1);
			default: return V_CNT_W'(V_FRONT - 1);
		endcase
	endfunction

	assign h_end = h_cnt == '0;
	assign v_end = v_cnt == '0;
	assign line_end = h_end && h_phase == PH_FRONT;

	// Horizontal phase counter
	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset) begin
			h_phase <= PH_SYNC;
			h_cnt <= h_reload(PH_SYNC);
		end else if (h_end) begin
			h_phase <= next_phase(h_phase);
			h_cnt <= h_reload(next_phase(h_phase));
		end else begin
			h_cnt <= h_cnt - 1'b1;
		end
	end

	// Vertical counter steps once per line
	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset) begin
			v_phase <= PH_SYNC;
			v_cnt <= v_reload(PH_SYNC);
		end else if (line_end) begin
			if (v_end) begin
				v_phase <= next_phase(v_phase);
				v_cnt <= v_reload(next_phase(v_phase));
			end else begin
				v_cnt <= v_cnt - 1'b1;
			end
		end
	end

	// First cycle of the first back porch line
	assign back_first = v_phase == PH_BACK && v_cnt == v_reload(PH_BACK)
		&& h_phase == PH_SYNC && h_cnt == h_reload(PH_SYNC);

	always_ff @(posedge clkSYS or negedge n_reset) begin
		if (!n_reset) begin
			tim.hsync_n <= 1'b0;
			tim.vsync_n <= 1'b0;
			tim.active <= 1'b0;
			tim.frame_start <= 1'b0;
		end else begin
			tim.hsync_n <= h_phase != PH_SYNC;
			tim.vsync_n <= v_phase != PH_SYNC;
			tim.active <= h_phase == PH_ACTIVE && v_phase == PH_ACTIVE;
			tim.frame_start <= back_first;
		end
	end

	// Frame restart must fall in blanking so no pixel is flushed mid-line
	a_start_in_blank: assert property (
		@(posedge clkSYS) disable iff (!n_reset)
		tim.frame_start |-> !tim.active
	) else $error("tft_timing: frame_start during active video");

endmodule

/* design/tft_timing_if.sv */
`timescale 1ns/1ps

// Raster timing from the generator to the fetch and output stages.
// All signals are registered in tft_timing and change on clkSYS.
interface tft_timing_if;

	// Sync pulses, low during the sync phase
	logic hsync_n;
	logic vsync_n;

	// High when both phases are active
	logic active;

	// Single cycle at the start of the vertical back porch
	logic frame_start;

	modport src (
		output hsync_n,
		output vsync_n,
		output active,
		output frame_start
	);

	modport dst (
		input hsync_n,
		input vsync_n,
		input active,
		input frame_start
	);

endinterface

/* tft_ctrl.f */
design/tft_pkg.sv
design/tft_timing_if.sv
design/pixel_fifo.sv
design/frame_fetch.sv
design/tft_timing.sv
design/pixel_out.sv
design/tft_ctrl.sv
verif/tb_tft_ctrl.sv

/* verif/tb_tft_ctrl.sv */
`timescale 1ns/1ps

module tb_tft_ctrl import tft_pkg::*; ();

	localparam int CLK_HALF = 50;
	localparam int RESET_CYCLES = 5;
	localparam int LINE_CYCLES = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;
	localparam int FRAME_CYCLES = LINE_CYCLES * (V_SYNC + V_BACK + V_ACTIVE + V_FRONT);
	localparam int FRAME_PIXELS = H_ACTIVE * V_ACTIVE;
	localparam int MEM_LATENCY = 3;
	// Startup frame and six test frames, three frames of margin
	localparam int TIMEOUT_CYCLES = 10 * FRAME_CYCLES + 200;

	// req_ready behaviour
	localparam int READY_HIGH = 0;
	localparam int READY_RANDOM = 1;
	localparam int READY_LOW = 2;

	// Pixel checking
	localparam int PIX_OFF = 0;
	localparam int PIX_EXACT = 1;
	localparam int PIX_UNDERRUN = 2;

	logic clkSYS = 1'b0;
	logic n_reset;
	logic [DATA_W-1:0] mem_data;
	logic mem_valid;
	logic req_ready;
	logic [ADDR_W-1:0] req_addr;
	logic request;
	logic disp;
	logic de;
	logic hsync;
	logic vsync;
	logic [RGB_W-1:0] rgb;
	logic underrun;
	logic [LEVEL_W-1:0] level;

	integer seed = 32'h4684;
	int cycle_count = 0;
	int ready_mode = READY_HIGH;
	int pix_mode = PIX_OFF;
	int pix_index = 0;
	bit seen_zero = 1'b0;
	bit vsync_prev = 1'b0;
	bit vsync_fell = 1'b0;
	bit vsync_rose = 1'b0;
	bit stalled = 1'b0;
	logic [ADDR_W-1:0] stall_addr;
	bit restart_armed = 1'b0;
	int restart_count = 0;

	// Burst memory model
	logic [ADDR_W-1:0] pend_addr [$];
	int pend_due [$];
	logic [ADDR_W-1:0] burst_addr;
	int burst_left = 0;

	tft_ctrl dut_i (
		.clkSYS (clkSYS),
		.n_reset (n_reset),
		.mem_data (mem_data),
		.mem_valid (mem_valid),
		.req_ready (req_ready),
		.req_addr (req_addr),
		.request (request),
		.disp (disp),
		.de (de),
		.hsync (hsync),
		.vsync (vsync),
		.rgb (rgb),
		.underrun (underrun),
		.level (level)
	);

	always #CLK_HALF clkSYS = ~clkSYS;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "Stopping at the first error");
	endtask

	always @(posedge clkSYS) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			abort_run($sformatf("Timeout: tests still running after %0d cycles",
				TIMEOUT_CYCLES));
	end

	// Memory content is a hash of the word address
	function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
		logic [31:0] prod;
		prod = 32'(addr) * 32'h0000_9E37;
		return prod[15:0];
	endfunction

	// RGB565 to RGB888 by zero fill of the low bits
	function automatic logic [RGB_W-1:0] expand565(input rgb565_t p);
		return {p.red, 3'b000, p.green, 2'b00, p.blue, 3'b000};
	endfunction

	function automatic logic [RGB_W-1:0] ref_pixel(input int k);
		return expand565(rgb565_t'(mem_word(FRAME_BASE + ADDR_W'(k))));
	endfunction

	task automatic drive_ready();
		if (!n_reset || ready_mode == READY_LOW)
			req_ready = 1'b0;
		else if (ready_mode == READY_RANDOM)
			req_ready = ($random(seed) & 3) != 0;
		else
			req_ready = 1'b1;
	endtask

	task automatic record_request();
		if (restart_armed) begin
			assert (req_addr == FRAME_BASE) else abort_run($sformatf(
				"Fail at %0t: first request after frame start at %h, expected %h",
				$time, req_addr, FRAME_BASE));
			restart_armed = 1'b0;
			restart_count++;
		end
		pend_addr.push_back(req_addr);
		pend_due.push_back(cycle_count + MEM_LATENCY);
	endtask

	// Bursts come back in order, one word per cycle
	task automatic drive_memory();
		if (burst_left == 0 && pend_due.size() > 0 && pend_due[0] <= cycle_count) begin
			burst_addr = pend_addr.pop_front();
			void'(pend_due.pop_front());
			burst_left = BURST_LEN;
		end
		if (burst_left > 0) begin
			mem_valid = 1'b1;
			mem_data = mem_word(burst_addr);
			burst_addr = burst_addr + 1'b1;
			burst_left--;
		end else begin
			mem_valid = 1'b0;
			mem_data = DATA_W'($random(seed));
		end
	endtask

	task automatic check_handshake();
		// Frame start may withdraw a stalled request
		if (stalled && !vsync_rose) begin
			assert (request && req_addr == stall_addr) else abort_run($sformatf(
				"Fail at %0t: stalled request changed, request %b addr %h, held addr %h",
				$time, request, req_addr, stall_addr));
		end
		assert (int'(level) <= FIFO_DEPTH) else abort_run($sformatf(
			"Fail at %0t: FIFO level %0d above depth", $time, level));
	endtask

	task automatic check_pixel();
		logic [RGB_W-1:0] expected;
		if (vsync_fell) begin
			pix_index = 0;
			seen_zero = 1'b0;
		end
		if (pix_mode != PIX_OFF && de) begin
			expected = ref_pixel(pix_index);
			if (pix_mode == PIX_EXACT) begin
				assert (rgb == expected) else abort_run($sformatf(
					"Fail at %0t: pixel %0d is %h, expected %h",
					$time, pix_index, rgb, expected));
				pix_index++;
			end else if (!seen_zero && rgb == expected) begin
				pix_index++;
			end else begin
				assert (rgb == '0) else abort_run($sformatf(
					"Fail at %0t: pixel %0d is %h, expected %h or black",
					$time, pix_index, rgb, seen_zero ? '0 : expected));
				seen_zero = 1'b1;
			end
		end
		if (pix_mode == PIX_EXACT) begin
			assert (!underrun) else abort_run($sformatf(
				"Fail at %0t: underrun set while data was available", $time));
		end
	endtask

	// One clock: sample outputs, check, then drive the next inputs
	task automatic step();
		logic accept;
		@(negedge clkSYS);
		vsync_fell = vsync_prev && !vsync;
		vsync_rose = !vsync_prev && vsync;
		vsync_prev = vsync;
		if (vsync_rose)
			restart_armed = 1'b1;
		if (n_reset) begin
			check_handshake();
			check_pixel();
		end
		drive_ready();
		accept = n_reset && request && req_ready;
		if (accept)
			record_request();
		drive_memory();
		stalled = n_reset && request && !req_ready;
		stall_addr = req_addr;
	endtask

	task automatic wait_frame();
		do
			step();
		while (!vsync_fell);
	endtask

	task automatic stream_frame(input int mode);
		wait_frame();
		pix_mode = mode;
		repeat (FRAME_CYCLES - 1)
			step();
		pix_mode = PIX_OFF;
	endtask

	task automatic check_idle_outputs(input string phase);
		assert (!request && !de && !disp && !underrun && rgb == '0) else abort_run(
			$sformatf("Fail at %0t: %s, request %b de %b disp %b underrun %b rgb %h",
			$time, phase, request, de, disp, underrun, rgb));
	endtask

	task automatic check_sync(input int i);
		int line;
		int col;
		bit h_exp;
		bit v_exp;
		bit de_exp;
		line = i / LINE_CYCLES;
		col = i % LINE_CYCLES;
		h_exp = col >= H_SYNC;
		v_exp = line >= V_SYNC;
		de_exp = line >= V_SYNC + V_BACK && line < V_SYNC + V_BACK + V_ACTIVE
			&& col >= H_SYNC + H_BACK && col < H_SYNC + H_BACK + H_ACTIVE;
		assert (hsync === h_exp && vsync === v_exp && de === de_exp) else abort_run(
			$sformatf("Fail at %0t: frame cycle %0d hsync %b vsync %b de %b, expected %b %b %b",
			$time, i, hsync, vsync, de, h_exp, v_exp, de_exp));
	endtask

	task automatic reset_test();
		n_reset = 1'b0;
		repeat (RESET_CYCLES) begin
			step();
			check_idle_outputs("during reset");
		end
		n_reset = 1'b1;
		repeat (3) begin
			step();
			check_idle_outputs("after reset");
			assert (!hsync && !vsync) else abort_run($sformatf(
				"Fail at %0t: sync not asserted after reset", $time));
		end
	endtask

	task automatic sync_shape_test();
		int i;
		int de_count;
		de_count = 0;
		wait_frame();
		for (i = 0; i < FRAME_CYCLES; i++) begin
			if (i > 0)
				step();
			check_sync(i);
			if (de)
				de_count++;
		end
		assert (de_count == FRAME_PIXELS) else abort_run($sformatf(
			"Fail at %0t: %0d active pixels in a frame", $time, de_count));
	endtask

	task automatic exact_frame_test(input int mode);
		ready_mode = mode;
		stream_frame(PIX_EXACT);
		assert (pix_index == FRAME_PIXELS) else abort_run($sformatf(
			"Fail at %0t: only %0d pixels checked in a frame", $time, pix_index));
		ready_mode = READY_HIGH;
	endtask

	task automatic frame_restart_test();
		int starts;
		starts = restart_count;
		exact_frame_test(READY_HIGH);
		exact_frame_test(READY_HIGH);
		assert (restart_count == starts + 2 && disp) else abort_run($sformatf(
			"Fail at %0t: %0d restarts in two frames, disp %b",
			$time, restart_count - starts, disp));
	endtask

	task automatic underrun_test();
		ready_mode = READY_LOW;
		stream_frame(PIX_UNDERRUN);
		assert (seen_zero && underrun) else abort_run($sformatf(
			"Fail at %0t: starved frame gave black %b underrun %b",
			$time, seen_zero, underrun));
	endtask

	initial begin
		n_reset = 1'b0;
		req_ready = 1'b0;
		mem_valid = 1'b0;
		mem_data = '0;
		reset_test();
		sync_shape_test();
		exact_frame_test(READY_HIGH);
		// Roughly a quarter of cycles stalled
		exact_frame_test(READY_RANDOM);
		frame_restart_test();
		underrun_test();
		$display("All tests passed");
		$finish;
	end

endmodule
